// File: Makefile
# Verilator build and run for the prefetch reader testbench

SIM  := obj_dir/Vprefetch_reader_tb
SRCS := $(wildcard source/*.sv source/*.svh tests/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): compile.f $(SRCS)
	verilator --binary --timing --assert -f compile.f \
		--top-module prefetch_reader_tb -o Vprefetch_reader_tb

# Pass is decided by the pass message in the log
run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

// File: compile.f
+incdir+source
source/prefetch_pkg.sv
source/fifo_wr_if.sv
source/fifo_small_prefetch.sv
source/burst_addr_counter.sv
source/fetch_sequencer_fsm.sv
source/mem_read_pipe.sv
source/prefetch_reader_top.sv
tests/tb_clock_gen.sv
tests/prefetch_reader_asserts.sv
tests/prefetch_reader_tb.sv

// File: source/burst_addr_counter.sv
// Burst address counter: steps the read address and counts down the remaining requests
`timescale 1ns/1ps

module burst_addr_counter import prefetch_pkg::*; (
    input  logic  clk,
    input  logic  srst,
    input  logic  load,
    input  logic  step,
    input  addr_t base_addr,
    input  len_t  length,
    output addr_t addr,
    output logic  last,
    output logic  zero_len
);

    // Requests still to issue in the current burst
    len_t remaining;

    // --------------------------------------------------
    // Address register
    // --------------------------------------------------
    // Wraps modulo the memory size through natural overflow
    always_ff @(posedge clk) begin
        if (load) begin
            addr <= base_addr;
        end else if (step) begin
            addr <= addr + 1'b1;
        end
    end

    // --------------------------------------------------
    // Remaining count
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            remaining <= '0;
        end else if (load) begin
            remaining <= length;
        end else if (step && !zero_len) begin
            remaining <= remaining - 1'b1;
        end
    end

    // One request left
    assign last     = (remaining == len_t'(1));
    // Nothing left, also the state after a zero-length load
    assign zero_len = (remaining == '0);

endmodule : burst_addr_counter

// File: source/fetch_sequencer_fsm.sv
// Fetch sequencer FSM: issues burst read requests under FIFO back-pressure and flags completion
`timescale 1ns/1ps

module fetch_sequencer_fsm import prefetch_pkg::*; (
    input  logic clk,
    input  logic srst,
    input  logic start,
    input  logic wr_rdy,
    input  logic last,
    input  logic zero_len,
    input  logic pipe_idle,
    output logic load,
    output logic step,
    output logic req,
    output logic busy,
    output logic done
);

    seq_state_t state;
    seq_state_t state_nxt;

    // --------------------------------------------------
    // State register
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // --------------------------------------------------
    // Next state and request issue
    // --------------------------------------------------
    always_comb begin
        state_nxt = state;
        load      = 1'b0;
        req       = 1'b0;
        case (state)
            IDLE: begin
                // Counter takes base and length on the same edge
                if (start) begin
                    load      = 1'b1;
                    state_nxt = FETCH;
                end
            end
            FETCH: begin
                if (zero_len) begin
                    // Empty burst, nothing to request
                    state_nxt = DRAIN;
                end else if (wr_rdy) begin
                    req = 1'b1;
                    if (last) begin
                        state_nxt = DRAIN;
                    end
                end
            end
            DRAIN: begin
                // Wait for the last read to land in the FIFO
                if (pipe_idle) begin
                    state_nxt = DONE;
                end
            end
            DONE:    state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    // Address advances with every request
    assign step = req;
    assign busy = (state == FETCH) || (state == DRAIN);
    assign done = (state == DONE);

endmodule : fetch_sequencer_fsm

// File: source/fifo_small_prefetch.sv
// Small synchronous prefetch FIFO with in-flight slot reservation and unregistered read data
`timescale 1ns/1ps
`include "prefetch_config.svh"

module fifo_small_prefetch import prefetch_pkg::*; (
    input  logic      clk,
    input  logic      srst,
    fifo_wr_if.sink   wr_port,
    input  logic      rd,
    output logic      rd_vld,
    output data_t     rd_data
);

    // --------------------------------------------------
    // Sizes
    // --------------------------------------------------
    localparam int PIPE      = `PF_PIPELINE_DEPTH;
    localparam int DEPTH     = PIPE * 2;
    localparam int PTR_WID   = $clog2(DEPTH);
    localparam int MEM_DEPTH = 2 ** PTR_WID;
    localparam int CNT_WID   = $clog2(DEPTH + 1);
    localparam int PCNT_WID  = $clog2(PIPE + 1);
    // Capacity at the width of count plus reserved slots
    localparam logic [CNT_WID:0] CAPACITY = (CNT_WID + 1)'(DEPTH);

    data_t               mem [MEM_DEPTH];
    logic [PTR_WID-1:0]  wr_ptr;
    logic [PTR_WID-1:0]  rd_ptr;
    logic [CNT_WID-1:0]  count;
    logic                full;
    logic                wr_safe;
    logic                rd_safe;
    // One bit per recent cycle in which wr_rdy was low
    logic [PIPE-1:0]     stall_hist;
    logic [PCNT_WID-1:0] reserved;
    logic [CNT_WID:0]    fill_level;

    // Number of set bits in the stall history
    function automatic logic [PCNT_WID-1:0] count_ones(input logic [PIPE-1:0] vec);
        logic [PCNT_WID-1:0] ones;
        ones = '0;
        for (int i = 0; i < PIPE; i++) begin
            ones = ones + PCNT_WID'(vec[i]);
        end
        return ones;
    endfunction

    // --------------------------------------------------
    // Fill control
    // --------------------------------------------------
    assign full    = (count == CNT_WID'(DEPTH));
    // Blocked writes on full, blocked reads on empty
    assign wr_safe = wr_port.wr && !full;
    assign rd_safe = rd && rd_vld;

    always_ff @(posedge clk) begin
        if (srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_safe) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_safe) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Net occupancy change, write and read may coincide
            count <= count + CNT_WID'(wr_safe) - CNT_WID'(rd_safe);
        end
    end

    // Pulse for one cycle after a write hits a full FIFO
    always_ff @(posedge clk) begin
        if (srst) begin
            wr_port.oflow <= 1'b0;
        end else begin
            wr_port.oflow <= wr_port.wr && full;
        end
    end

    // --------------------------------------------------
    // Reserved slots for in-flight writes
    // --------------------------------------------------
    // A cycle with wr_rdy low issued no request, so it frees one reserved slot
    always_ff @(posedge clk) begin
        if (srst) begin
            stall_hist <= '0;
        end else begin
            stall_hist <= {stall_hist[PIPE-2:0], !wr_port.wr_rdy};
        end
    end

    assign reserved       = PCNT_WID'(PIPE) - count_ones(stall_hist);
    assign fill_level     = (CNT_WID + 1)'(count) + (CNT_WID + 1)'(reserved);
    assign wr_port.wr_rdy = fill_level < CAPACITY;

    // --------------------------------------------------
    // Storage
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (wr_safe) begin
            mem[wr_ptr] <= wr_port.wr_data;
        end
    end

    // Read data straight from storage, valid while rd_vld is high
    assign rd_data = mem[rd_ptr];
    assign rd_vld  = (count != '0);

endmodule : fifo_small_prefetch

// File: source/fifo_wr_if.sv
// FIFO write side bundle between the memory read pipeline and the prefetch FIFO
`timescale 1ns/1ps

interface fifo_wr_if import prefetch_pkg::*; ();

    // Write strobe, a word is taken on every cycle it is high
    logic  wr;
    data_t wr_data;
    // Advisory ready, in-flight writes still fit after it falls
    logic  wr_rdy;
    // One-cycle pulse on a write into a full FIFO
    logic  oflow;

    // Requester side
    modport source (
        output wr,
        output wr_data,
        input  wr_rdy,
        input  oflow
    );

    // FIFO side
    modport sink (
        input  wr,
        input  wr_data,
        output wr_rdy,
        output oflow
    );

endinterface : fifo_wr_if

// File: source/mem_read_pipe.sv
// Loadable on-chip memory with a fixed-latency read pipeline feeding the FIFO write side
`timescale 1ns/1ps
`include "prefetch_config.svh"

module mem_read_pipe import prefetch_pkg::*; (
    input  logic      clk,
    input  logic      srst,
    input  logic      load_en,
    input  addr_t     load_addr,
    input  data_t     load_data,
    input  logic      req,
    input  addr_t     addr,
    output logic      idle,
    fifo_wr_if.source wr_port
);

    localparam int LAT       = `PF_MEM_LATENCY;
    localparam int MEM_WORDS = 2 ** `PF_ADDR_WIDTH;

    // The FIFO reservation window must cover every read in flight
    if (`PF_PIPELINE_DEPTH < LAT) begin : g_window_check
        $error("Prefetch window shorter than memory latency");
    end

    data_t           mem [MEM_WORDS];
    // Stage 0 is the memory read, the rest only delay the word
    data_t           data_sr [LAT];
    logic [LAT-1:0]  vld_sr;

    // --------------------------------------------------
    // Load port
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    // --------------------------------------------------
    // Read pipeline
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        data_sr[0] <= mem[addr];
        for (int i = 1; i < LAT; i++) begin
            data_sr[i] <= data_sr[i-1];
        end
    end

    // Valid flags, cleared so a reset drops reads in flight
    always_ff @(posedge clk) begin
        if (srst) begin
            vld_sr <= '0;
        end else begin
            vld_sr[0] <= req;
            for (int i = 1; i < LAT; i++) begin
                vld_sr[i] <= vld_sr[i-1];
            end
        end
    end

    // Last stage writes the FIFO
    assign wr_port.wr      = vld_sr[LAT-1];
    assign wr_port.wr_data = data_sr[LAT-1];
    assign idle            = (vld_sr == '0);

endmodule : mem_read_pipe

// File: source/prefetch_config.svh
// Prefetch reader configuration: bus widths, memory latency and prefetch window
`ifndef PREFETCH_CONFIG_SVH
`define PREFETCH_CONFIG_SVH

// --------------------------------------------------
// Widths
// --------------------------------------------------
// Memory address, 256 words
`define PF_ADDR_WIDTH 8
`define PF_DATA_WIDTH 16
// Burst length, wide enough to hold 256
`define PF_LEN_WIDTH 9

// --------------------------------------------------
// Timing
// --------------------------------------------------
// Cycles from a read request to its FIFO write
`define PF_MEM_LATENCY 3
// Writes tolerated after wr_rdy falls, at least PF_MEM_LATENCY
`define PF_PIPELINE_DEPTH 4

`endif

// File: source/prefetch_pkg.sv
// Prefetch reader types: address, data and length vectors plus sequencer states
`include "prefetch_config.svh"

package prefetch_pkg;

    // --------------------------------------------------
    // Vector types
    // --------------------------------------------------
    // Word address into the on-chip memory
    typedef logic [`PF_ADDR_WIDTH-1:0] addr_t;
    // One memory word
    typedef logic [`PF_DATA_WIDTH-1:0] data_t;
    // Burst length, zero to 256
    typedef logic [`PF_LEN_WIDTH-1:0]  len_t;

    // --------------------------------------------------
    // Sequencer FSM
    // --------------------------------------------------
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        FETCH = 2'd1,
        DRAIN = 2'd2,
        DONE  = 2'd3
    } seq_state_t;

endpackage : prefetch_pkg

// File: source/prefetch_reader_top.sv
// Memory read prefetcher top: sequencer, address counter, read pipeline and prefetch FIFO
`timescale 1ns/1ps

module prefetch_reader_top import prefetch_pkg::*; (
    input  logic  clk,
    input  logic  srst,
    // Memory load port
    input  logic  load_en,
    input  addr_t load_addr,
    input  data_t load_data,
    // Burst control
    input  logic  start,
    input  addr_t base_addr,
    input  len_t  length,
    output logic  busy,
    output logic  done,
    // Consumer side
    input  logic  rd,
    output logic  rd_vld,
    output data_t rd_data,
    output logic  oflow
);

    logic  seq_load;
    logic  seq_step;
    logic  seq_req;
    logic  cnt_last;
    logic  cnt_zero_len;
    logic  pipe_idle;
    addr_t rd_addr;

    // --------------------------------------------------
    // FIFO write side
    // --------------------------------------------------
    fifo_wr_if wr_if ();

    assign oflow = wr_if.oflow;

    // --------------------------------------------------
    // Blocks
    // --------------------------------------------------
    fetch_sequencer_fsm i_seq (
        .clk       (clk),
        .srst      (srst),
        .start     (start),
        .wr_rdy    (wr_if.wr_rdy),
        .last      (cnt_last),
        .zero_len  (cnt_zero_len),
        .pipe_idle (pipe_idle),
        .load      (seq_load),
        .step      (seq_step),
        .req       (seq_req),
        .busy      (busy),
        .done      (done)
    );

    burst_addr_counter i_cnt (
        .clk       (clk),
        .srst      (srst),
        .load      (seq_load),
        .step      (seq_step),
        .base_addr (base_addr),
        .length    (length),
        .addr      (rd_addr),
        .last      (cnt_last),
        .zero_len  (cnt_zero_len)
    );

    mem_read_pipe i_pipe (
        .clk       (clk),
        .srst      (srst),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .req       (seq_req),
        .addr      (rd_addr),
        .idle      (pipe_idle),
        .wr_port   (wr_if.source)
    );

    fifo_small_prefetch i_fifo (
        .clk       (clk),
        .srst      (srst),
        .wr_port   (wr_if.sink),
        .rd        (rd),
        .rd_vld    (rd_vld),
        .rd_data   (rd_data)
    );

endmodule : prefetch_reader_top

// File: tests/prefetch_reader_asserts.sv
// Prefetch reader protocol checks on done, busy, rd_vld and oflow
`timescale 1ns/1ps

module prefetch_reader_asserts (
    input logic clk,
    input logic srst,
    input logic busy,
    input logic done,
    input logic rd_vld,
    input logic oflow
);

    // --------------------------------------------------
    // Sequencer completion
    // --------------------------------------------------
    // DONE lasts one state only
    done_single_pulse: assert property (@(posedge clk) disable iff (srst) done |=> !done)
        else $error("done stayed high for more than one cycle");

    // DONE is only reached from DRAIN, where busy is high
    done_after_busy: assert property (@(posedge clk) disable iff (srst) done |-> $past(busy))
        else $error("done without a busy burst before it");

    // --------------------------------------------------
    // FIFO
    // --------------------------------------------------
    // Reset empties the FIFO
    rd_vld_low_after_reset: assert property (@(posedge clk) srst |=> !rd_vld)
        else $error("rd_vld high on the cycle after srst");

    // Reserved slots must absorb every read in flight
    no_overflow: assert property (@(posedge clk) disable iff (srst) !oflow)
        else $error("oflow raised, FIFO written while full");

endmodule : prefetch_reader_asserts

bind prefetch_reader_top prefetch_reader_asserts i_asserts (.*);

// File: tests/prefetch_reader_tb.sv
// Prefetch reader testbench: memory load, burst reads, back-pressure, reset and reference compare
`timescale 1ns/1ps
`include "prefetch_config.svh"

module prefetch_reader_tb import prefetch_pkg::*; ();

    localparam int CLK_PERIOD  = 100;
    localparam int MEM_WORDS   = 2 ** `PF_ADDR_WIDTH;
    // Words requested over all bursts, the one cut by reset included
    localparam int TOTAL_WORDS = 20 + 60 + 12 + 16 + 40 + 24;
    localparam int MARGIN      = 12;
    localparam int BUDGET      = MEM_WORDS + 200 + TOTAL_WORDS * MARGIN;

    logic  clk;
    logic  srst;
    logic  load_en;
    addr_t load_addr;
    data_t load_data;
    logic  start;
    addr_t base_addr;
    len_t  length;
    logic  busy;
    logic  done;
    logic  rd;
    logic  rd_vld;
    data_t rd_data;
    logic  oflow;

    // Memory model, mirrors every load
    data_t       model [MEM_WORDS];
    int          cur_base;
    int          cur_len;
    int          burst_seq;
    int          seen_seq;
    int          pop_count;
    int          done_count;
    int          words_checked;
    int          value_errors;
    int          extra_words;
    int          other_errors;
    int unsigned rd_pct;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD)) i_clk (.clk(clk));

    prefetch_reader_top i_dut (
        .clk       (clk),
        .srst      (srst),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .start     (start),
        .base_addr (base_addr),
        .length    (length),
        .busy      (busy),
        .done      (done),
        .rd        (rd),
        .rd_vld    (rd_vld),
        .rd_data   (rd_data),
        .oflow     (oflow)
    );

    // Expected word idx of a burst, address wraps modulo the memory size
    function automatic data_t ref_word(input int base, input int idx);
        return model[(base + idx) % MEM_WORDS];
    endfunction

    // Inputs change 10 ns after each rising edge
    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic load_memory();
        data_t word;
        int    a;
        for (a = 0; a < MEM_WORDS; a++) begin
            word      = data_t'($urandom);
            model[a]  = word;
            load_en   = 1'b1;
            load_addr = addr_t'(a);
            load_data = word;
            next_cycle();
        end
        load_en = 1'b0;
    endtask

    // One-cycle start pulse, the compare side restarts its word index
    task automatic issue_start(input addr_t base, input len_t len);
        cur_base  = int'(base);
        cur_len   = int'(len);
        burst_seq = burst_seq + 1;
        base_addr = base;
        length    = len;
        start     = 1'b1;
        next_cycle();
        start = 1'b0;
    endtask

    // --------------------------------------------------
    // Burst with done, count and drain checks
    // --------------------------------------------------
    task automatic run_burst(input addr_t base, input len_t len, input bit poke_start);
        int limit;
        int n;
        limit = int'(len) * MARGIN + 40;
        issue_start(base, len);
        if (poke_start) begin
            repeat (3) next_cycle();
            assert (busy) else begin
                other_errors++;
                $display("Burst at %0d not busy when the second start was sent", base);
            end
            // Must be ignored, counter keeps the first burst
            base_addr = base + 8'd77;
            length    = len + 9'd5;
            start     = 1'b1;
            next_cycle();
            start = 1'b0;
        end
        n = 0;
        while (!done && n < limit) begin
            next_cycle();
            n++;
        end
        assert (done) else begin
            other_errors++;
            $display("Burst at %0d never signalled done", base);
        end
        assert (!busy) else begin
            other_errors++;
            $display("busy still high at done for burst at %0d", base);
        end
        n = 0;
        while (pop_count < cur_len && n < limit) begin
            next_cycle();
            n++;
        end
        // Some spare cycles so any surplus word shows up
        repeat (4) next_cycle();
        assert (pop_count == cur_len) else begin
            other_errors++;
            $display("Burst at %0d gave %0d words, %0d wanted", base, pop_count, cur_len);
        end
        assert (!rd_vld) else begin
            other_errors++;
            $display("FIFO not empty after burst at %0d", base);
        end
        assert (done_count == 1) else begin
            other_errors++;
            $display("Burst at %0d gave %0d done pulses", base, done_count);
        end
    endtask

    task automatic reset_mid_burst();
        issue_start(8'd60, 9'd40);
        repeat (12) next_cycle();
        assert (busy) else begin
            other_errors++;
            $display("Burst not running before the mid-burst reset");
        end
        srst = 1'b1;
        next_cycle();
        assert (!rd_vld && !busy) else begin
            other_errors++;
            $display("rd_vld or busy still high after reset");
        end
        next_cycle();
        srst = 1'b0;
    endtask

    // --------------------------------------------------
    // Consumer, rd at rd_pct percent
    // --------------------------------------------------
    initial begin : drive_rd
        rd = 1'b0;
        forever begin
            @(posedge clk);
            #10;
            rd = ($urandom % 100) < rd_pct;
        end
    end

    // Checked half a cycle after the drive, popped at the next edge
    always @(negedge clk) begin : compare_words
        data_t expected;
        if (burst_seq != seen_seq) begin
            seen_seq   = burst_seq;
            pop_count  = 0;
            done_count = 0;
        end
        if (!srst) begin
            if (done) begin
                done_count++;
            end
            assert (!oflow) else begin
                value_errors++;
                $display("[FAIL] time %0t: oflow expected 0, got %b", $time, oflow);
            end
            if (rd && rd_vld) begin
                assert (pop_count < cur_len) else begin
                    extra_words++;
                    $display("Word popped past the burst length at time %0t", $time);
                end
                expected = ref_word(cur_base, pop_count);
                assert (rd_data == expected) else begin
                    value_errors++;
                    $display("[FAIL] time %0t: rd_data expected %h, got %h",
                             $time, expected, rd_data);
                end
                pop_count++;
                words_checked++;
            end
        end
    end

    // --------------------------------------------------
    // Watchdog
    // --------------------------------------------------
    initial begin : watchdog
        #(BUDGET * CLK_PERIOD);
        $display("Timeout after %0d cycles, run stopped", BUDGET);
        $display("Test failures found");
        $finish;
    end

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin : stimulus
        void'($urandom(16213));
        srst          = 1'b1;
        load_en       = 1'b0;
        load_addr     = '0;
        load_data     = '0;
        start         = 1'b0;
        base_addr     = '0;
        length        = '0;
        rd_pct        = 0;
        cur_base      = 0;
        cur_len       = 0;
        burst_seq     = 0;
        seen_seq      = 0;
        words_checked = 0;
        value_errors  = 0;
        extra_words   = 0;
        other_errors  = 0;
        repeat (5) @(posedge clk);
        #10;
        srst = 1'b0;
        load_memory();
        // Full-rate consumer
        rd_pct = 100;
        run_burst(8'd17, 9'd20, 1'b0);
        // Slow consumer, FIFO back-pressure
        rd_pct = 30;
        run_burst(8'd100, 9'd60, 1'b0);
        // Wraps through address 0
        rd_pct = 100;
        run_burst(8'd250, 9'd12, 1'b0);
        // Start while busy, then an empty burst
        rd_pct = 60;
        run_burst(8'd40, 9'd16, 1'b1);
        run_burst(8'd5, 9'd0, 1'b0);
        // Memory contents survive the reset
        rd_pct = 50;
        reset_mid_burst();
        rd_pct = 100;
        run_burst(8'd200, 9'd24, 1'b0);
        $display("Summary: %0d words checked, %0d value errors, %0d extra words, %0d other errors",
                 words_checked, value_errors, extra_words, other_errors);
        if (value_errors == 0 && extra_words == 0 && other_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule : prefetch_reader_tb

// File: tests/tb_clock_gen.sv
// Testbench clock source, free-running square wave
`timescale 1ns/1ps

module tb_clock_gen #(
    // Full period in ns
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    // Low at time zero so the first rising edge lands at half a period
    initial begin
        clk = 1'b0;
    end

    always #(PERIOD_NS / 2) clk = ~clk;

endmodule : tb_clock_gen
